/* rtl/output_mem_params.svh */
`ifndef OUTPUT_MEM_PARAMS_SVH
`define OUTPUT_MEM_PARAMS_SVH

// width of one host databus word
`define OM_DATA_W 32

// local memory address width, 256 words
`define OM_ADDR_W 8

// addresses per period of the pattern
`define OM_PERIOD_W 10

// idle cycles before the first address
`define OM_DELAY_W 7

`endif

/* rtl/bus_pkg.sv */
`default_nettype none

`include "output_mem_params.svh"

package bus_pkg;

   // one data word on the host databus
   typedef logic [`OM_DATA_W-1:0] word_t;

   // one local memory address
   typedef logic [`OM_ADDR_W-1:0] addr_t;

   // byte strobes, one per byte of a word
   typedef logic [`OM_DATA_W/8-1:0] strb_t;

endpackage

`default_nettype wire

/* rtl/agen_pkg.sv */
`default_nettype none

`include "output_mem_params.svh"

package agen_pkg;

   // address count inside one period
   typedef logic [`OM_PERIOD_W-1:0] period_t;

   // start delay in clock cycles
   typedef logic [`OM_DELAY_W-1:0] delay_t;

   // run phases of the address generator
   typedef enum logic [1:0] {AG_IDLE, AG_DELAY, AG_STREAM} ag_state_t;

endpackage

`default_nettype wire

/* rtl/addr_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module addr_gen (
   input  wire                clk,
   input  wire                rst,
   input  wire                run_i,
   input  bus_pkg::addr_t     iter_i,
   input  bus_pkg::addr_t     start_i,
   input  bus_pkg::addr_t     incr_i,
   input  bus_pkg::addr_t     shift_i,
   input  agen_pkg::period_t  per_i,
   input  agen_pkg::delay_t   delay_i,
   output logic               valid_o,
   output bus_pkg::addr_t     addr_o,
   output logic               done_o
);

   import bus_pkg::*;
   import agen_pkg::*;

   ag_state_t state_q;
   delay_t    delay_cnt_q;
   period_t   per_cnt_q;
   addr_t     iter_cnt_q;
   addr_t     base_q;
   logic      last_in_per;
   logic      last_iter;
   logic      empty_cfg;

   // position inside the two-level walk
   assign last_in_per = (per_cnt_q == per_i - period_t'(1));
   assign last_iter   = (iter_cnt_q == iter_i - addr_t'(1));

   // a zero count gives a pattern with no addresses
   assign empty_cfg = (per_i == '0) || (iter_i == '0);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q     <= AG_IDLE;
         delay_cnt_q <= '0;
         per_cnt_q   <= '0;
         iter_cnt_q  <= '0;
         base_q      <= '0;
         addr_o      <= '0;
         valid_o     <= 1'b0;
         done_o      <= 1'b1;
      end else if (run_i) begin
         // a new run restarts the pattern from any state
         state_q     <= AG_DELAY;
         delay_cnt_q <= delay_i;
         valid_o     <= 1'b0;
         done_o      <= 1'b0;
      end else begin
         case (state_q)
            AG_DELAY: begin
               if (delay_cnt_q != '0) begin
                  delay_cnt_q <= delay_cnt_q - delay_t'(1);
               end else if (empty_cfg) begin
                  state_q <= AG_IDLE;
                  done_o  <= 1'b1;
               end else begin
                  // first address of the first period
                  state_q    <= AG_STREAM;
                  base_q     <= start_i;
                  addr_o     <= start_i;
                  per_cnt_q  <= '0;
                  iter_cnt_q <= '0;
                  valid_o    <= 1'b1;
               end
            end
            AG_STREAM: begin
               if (!last_in_per) begin
                  addr_o    <= addr_o + incr_i;
                  per_cnt_q <= per_cnt_q + period_t'(1);
               end else if (!last_iter) begin
                  // period end, base moves by the shift
                  base_q     <= base_q + shift_i;
                  addr_o     <= base_q + shift_i;
                  per_cnt_q  <= '0;
                  iter_cnt_q <= iter_cnt_q + addr_t'(1);
               end else begin
                  // last address was shown in the cycle before this edge
                  state_q <= AG_IDLE;
                  valid_o <= 1'b0;
                  done_o  <= 1'b1;
               end
            end
            default: begin
               valid_o <= 1'b0;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* rtl/two_port_ram.sv */
`timescale 1ns/10ps
`default_nettype none

`include "output_mem_params.svh"

module two_port_ram (
   input  wire              clk,
   input  wire              we_i,
   input  bus_pkg::addr_t   waddr_i,
   input  bus_pkg::word_t   wdata_i,
   input  wire              re_i,
   input  bus_pkg::addr_t   raddr_i,
   output bus_pkg::word_t   rdata_o
);

   import bus_pkg::*;

   word_t mem [0:(1 << `OM_ADDR_W)-1];

   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[waddr_i] <= wdata_i;
      end
   end

   // read word holds while re is low
   always_ff @(posedge clk) begin
      if (re_i) begin
         rdata_o <= mem[raddr_i];
      end
   end

endmodule

`default_nettype wire

/* rtl/output_mem_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module output_mem_unit (
   input  wire                clk,
   input  wire                rst,
   input  wire                run_i,
   input  wire                disabled_i,
   input  wire                running_i,
   // host write group
   input  wire                valid_i,
   input  bus_pkg::strb_t     wstrb_i,
   input  bus_pkg::addr_t     addr_i,
   input  bus_pkg::word_t     wdata_i,
   // pattern configuration
   input  bus_pkg::addr_t     iter_i,
   input  agen_pkg::period_t  per_i,
   input  bus_pkg::addr_t     start_i,
   input  bus_pkg::addr_t     incr_i,
   input  bus_pkg::addr_t     shift_i,
   input  agen_pkg::delay_t   delay_i,
   // memory ports
   output logic               mem_we_o,
   output bus_pkg::addr_t     mem_waddr_o,
   output bus_pkg::word_t     mem_wdata_o,
   output logic               mem_re_o,
   output bus_pkg::addr_t     mem_raddr_o,
   input  bus_pkg::word_t     mem_rdata_i,
   // status and stream
   output logic               done_o,
   output bus_pkg::word_t     out_o
);

   import bus_pkg::*;

   word_t out_q;

   // strobes act as a single word write enable
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         mem_we_o <= 1'b0;
      end else begin
         mem_we_o <= valid_i & (|wstrb_i);
      end
   end

   always_ff @(posedge clk) begin
      if (valid_i) begin
         mem_waddr_o <= addr_i;
         mem_wdata_o <= wdata_i;
      end
   end

   // read side driven straight by the generator
   addr_gen u_addr_gen (
      .clk     (clk),
      .rst     (rst),
      .run_i   (run_i & ~disabled_i),
      .iter_i  (iter_i),
      .start_i (start_i),
      .incr_i  (incr_i),
      .shift_i (shift_i),
      .per_i   (per_i),
      .delay_i (delay_i),
      .valid_o (mem_re_o),
      .addr_o  (mem_raddr_o),
      .done_o  (done_o)
   );

   // second stage of the two cycle read latency
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         out_q <= '0;
      end else begin
         out_q <= mem_rdata_i;
      end
   end

   assign out_o = running_i ? out_q : '0;

endmodule

`default_nettype wire

/* rtl/output_mem_top.sv */
`timescale 1ns/10ps
`default_nettype none

module output_mem_top (
   input  wire                clk,
   input  wire                rst,
   input  wire                run_i,
   input  wire                disabled_i,
   input  wire                running_i,
   input  wire                valid_i,
   input  bus_pkg::strb_t     wstrb_i,
   input  bus_pkg::addr_t     addr_i,
   input  bus_pkg::word_t     wdata_i,
   input  bus_pkg::addr_t     iter_i,
   input  agen_pkg::period_t  per_i,
   input  bus_pkg::addr_t     start_i,
   input  bus_pkg::addr_t     incr_i,
   input  bus_pkg::addr_t     shift_i,
   input  agen_pkg::delay_t   delay_i,
   output wire                done_o,
   output bus_pkg::word_t     out_o
);

   import bus_pkg::*;

   // unit to memory
   logic  mem_we;
   addr_t mem_waddr;
   word_t mem_wdata;
   logic  mem_re;
   addr_t mem_raddr;
   word_t mem_rdata;

   output_mem_unit u_unit (
      .clk         (clk),
      .rst         (rst),
      .run_i       (run_i),
      .disabled_i  (disabled_i),
      .running_i   (running_i),
      .valid_i     (valid_i),
      .wstrb_i     (wstrb_i),
      .addr_i      (addr_i),
      .wdata_i     (wdata_i),
      .iter_i      (iter_i),
      .per_i       (per_i),
      .start_i     (start_i),
      .incr_i      (incr_i),
      .shift_i     (shift_i),
      .delay_i     (delay_i),
      .mem_we_o    (mem_we),
      .mem_waddr_o (mem_waddr),
      .mem_wdata_o (mem_wdata),
      .mem_re_o    (mem_re),
      .mem_raddr_o (mem_raddr),
      .mem_rdata_i (mem_rdata),
      .done_o      (done_o),
      .out_o       (out_o)
   );

   two_port_ram u_ram (
      .clk     (clk),
      .we_i    (mem_we),
      .waddr_i (mem_waddr),
      .wdata_i (mem_wdata),
      .re_i    (mem_re),
      .raddr_i (mem_raddr),
      .rdata_o (mem_rdata)
   );

endmodule

`default_nettype wire

/* test/tb_output_mem_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "output_mem_params.svh"

module tb_output_mem_top;

   import bus_pkg::*;
   import agen_pkg::*;

   logic    clk;
   logic    rst;
   logic    run;
   logic    disabled;
   logic    running;
   logic    valid;
   strb_t   wstrb;
   addr_t   addr;
   word_t   wdata;
   addr_t   iter;
   period_t per;
   addr_t   start;
   addr_t   incr;
   addr_t   shift;
   delay_t  delay;
   logic    done;
   word_t   dout;

   // mirror of the local memory
   word_t mirror [0:(1 << `OM_ADDR_W)-1];

   // test table
   string   t_name  [0:7];
   addr_t   t_start [0:7];
   addr_t   t_incr  [0:7];
   addr_t   t_shift [0:7];
   period_t t_per   [0:7];
   addr_t   t_iter  [0:7];
   delay_t  t_delay [0:7];
   logic    t_dis   [0:7];
   logic    t_run   [0:7];
   int      n_tests;

   logic [31:0] lfsr_q = 32'h763b9285;
   string       cur_name;
   int          test_errors;
   int          error_count;
   int          check_count;
   int          failed_tests;

   output_mem_top u_dut (
      .clk        (clk),
      .rst        (rst),
      .run_i      (run),
      .disabled_i (disabled),
      .running_i  (running),
      .valid_i    (valid),
      .wstrb_i    (wstrb),
      .addr_i     (addr),
      .wdata_i    (wdata),
      .iter_i     (iter),
      .per_i      (per),
      .start_i    (start),
      .incr_i     (incr),
      .shift_i    (shift),
      .delay_i    (delay),
      .done_o     (done),
      .out_o      (dout)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // fibonacci lfsr, taps 32 22 2 1
   function automatic logic next_bit();
      logic fb;
      fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      return fb;
   endfunction

   function automatic word_t rand_word();
      word_t w;
      w = '0;
      for (int b = 0; b < `OM_DATA_W; b++) begin
         w = {w[`OM_DATA_W-2:0], next_bit()};
      end
      return w;
   endfunction

   task automatic check_value(input string what, input word_t exp, input word_t act);
      check_count++;
      assert (act === exp) else begin
         $display("CHECK FAILED test=%s %s expected=%h actual=%h", cur_name, what, exp, act);
         error_count++;
         test_errors++;
      end
   endtask

   task automatic add_test(input string name, input addr_t st, input addr_t inc,
                           input addr_t sh, input period_t pr, input addr_t it,
                           input delay_t dl, input logic dis, input logic rn);
      t_name[n_tests]  = name;
      t_start[n_tests] = st;
      t_incr[n_tests]  = inc;
      t_shift[n_tests] = sh;
      t_per[n_tests]   = pr;
      t_iter[n_tests]  = it;
      t_delay[n_tests] = dl;
      t_dis[n_tests]   = dis;
      t_run[n_tests]   = rn;
      n_tests++;
   endtask

   task automatic host_write(input addr_t a, input word_t w, input strb_t s);
      @(posedge clk);
      valid <= 1'b1;
      wstrb <= s;
      addr  <= a;
      wdata <= w;
      @(posedge clk);
      valid <= 1'b0;
      wstrb <= '0;
   endtask

   task automatic load_memory();
      word_t w;
      for (int a = 0; a < (1 << `OM_ADDR_W); a++) begin
         w = rand_word();
         mirror[a] = w;
         host_write(addr_t'(a), w, 4'hf);
      end
   endtask

   task automatic wait_done(input int limit);
      int cnt;
      cnt = 0;
      while (done !== 1'b1 && cnt < limit) begin
         @(negedge clk);
         cnt++;
      end
      if (done !== 1'b1) begin
         $display("ERROR test=%s done_o did not rise within %0d cycles", cur_name, limit);
         error_count++;
         test_errors++;
      end
   endtask

   task automatic run_test(input int idx);
      addr_t seq [$];
      int    d;
      int    nw;
      int    j;
      logic  exp_done;
      cur_name = t_name[idx];
      test_errors = 0;
      seq.delete();
      // base moves by shift per period, address by incr inside it, wrapping at 256
      for (int it = 0; it < int'(t_iter[idx]); it++) begin
         for (int p = 0; p < int'(t_per[idx]); p++) begin
            seq.push_back(addr_t'(int'(t_start[idx]) + it * int'(t_shift[idx])
                                  + p * int'(t_incr[idx])));
         end
      end
      d  = int'(t_delay[idx]);
      nw = seq.size();
      @(posedge clk);
      start    <= t_start[idx];
      incr     <= t_incr[idx];
      shift    <= t_shift[idx];
      per      <= t_per[idx];
      iter     <= t_iter[idx];
      delay    <= t_delay[idx];
      disabled <= t_dis[idx];
      running  <= t_run[idx];
      run      <= 1'b1;
      // edge T, where the run pulse is taken
      @(posedge clk);
      run <= 1'b0;
      for (int n = 0; n <= d + nw + 2; n++) begin
         @(negedge clk);
         exp_done = t_dis[idx] ? 1'b1 : (n >= d + nw + 1);
         check_value("done_o", word_t'(exp_done), word_t'(done));
         // word of address j shows 2 cycles after edge T+1+d+j
         j = n - d - 3;
         if (!t_run[idx]) begin
            check_value("out_o gated", '0, dout);
         end else if (!t_dis[idx] && j >= 0 && j < nw) begin
            check_value($sformatf("out_o[%0d]", j), mirror[seq[j]], dout);
         end
      end
      wait_done(64);
      if (test_errors != 0) begin
         failed_tests++;
      end
      $display("test %-12s %s (%0d errors)", cur_name, (test_errors == 0) ? "ok" : "FAIL",
               test_errors);
   endtask

   initial begin
      rst = 1'b1;
      run = 1'b0;
      disabled = 1'b0;
      running = 1'b1;
      valid = 1'b0;
      wstrb = '0;
      addr = '0;
      wdata = '0;
      iter = '0;
      per = '0;
      start = '0;
      incr = '0;
      shift = '0;
      delay = '0;
      n_tests = 0;
      error_count = 0;
      check_count = 0;
      failed_tests = 0;
      add_test("wr_nostrobe", 8'h40, 8'd1, 8'd0, 10'd1, 8'd1, 7'd0, 1'b0, 1'b1);
      add_test("wr_strobed", 8'h41, 8'd1, 8'd0, 10'd1, 8'd1, 7'd0, 1'b0, 1'b1);
      add_test("linear", 8'd5, 8'd1, 8'd0, 10'd16, 8'd1, 7'd0, 1'b0, 1'b1);
      add_test("two_level", 8'd200, 8'd3, 8'd32, 10'd4, 8'd3, 7'd0, 1'b0, 1'b1);
      add_test("start_delay", 8'd200, 8'd3, 8'd32, 10'd4, 8'd3, 7'd9, 1'b0, 1'b1);
      add_test("disabled", 8'd5, 8'd1, 8'd0, 10'd8, 8'd1, 7'd0, 1'b1, 1'b1);
      add_test("gated", 8'd5, 8'd1, 8'd0, 10'd8, 8'd1, 7'd0, 1'b0, 1'b0);
      for (int i = 0; i < 16; i++) begin
         @(posedge clk);
      end
      rst <= 1'b0;
      @(negedge clk);
      cur_name = "reset";
      test_errors = 0;
      check_value("done_o", word_t'(1), word_t'(done));
      check_value("out_o", '0, dout);
      $display("test %-12s %s (%0d errors)", cur_name, (test_errors == 0) ? "ok" : "FAIL",
               test_errors);
      if (test_errors != 0) begin
         failed_tests++;
      end
      load_memory();
      // write without strobes must leave the word alone
      host_write(8'h40, rand_word(), 4'h0);
      mirror[8'h41] = rand_word();
      host_write(8'h41, mirror[8'h41], 4'h4);
      for (int i = 0; i < n_tests; i++) begin
         run_test(i);
      end
      $display("summary: %0d tests, %0d failed, %0d checks, %0d errors", n_tests + 1,
               failed_tests, check_count, error_count);
      if (error_count == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* output_mem_top.f */
+incdir+rtl
rtl/bus_pkg.sv
rtl/agen_pkg.sv
rtl/addr_gen.sv
rtl/two_port_ram.sv
rtl/output_mem_unit.sv
rtl/output_mem_top.sv
test/tb_output_mem_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/10ps \
   -f output_mem_top.f --top-module tb_output_mem_top -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "All tests passed" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
